//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_cam_cfg
FLIST     := all.f
OBJDIR    := obj_dir
LOG       := sim.log

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Regression failed" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
+incdir+common
common/cam_cfg_pkg.sv
common/sccb_cmd_if.sv
sccb/sccb_master.sv
verilog/cam_cfg_apb_regs.sv
verilog/cam_cfg_sequencer.sv
verilog/cam_cfg_top.sv
tests/sccb_bus_monitor.sv
tests/tb_cam_cfg.sv

//--- common/cam_cfg_params.svh
// shared parameters for the camera config subsystem
// sccb quarter-period divider, init table length, apb register offsets

`ifndef CAM_CFG_PARAMS_SVH
`define CAM_CFG_PARAMS_SVH

// clocks per quarter of an sccb bit period
// 4 keeps simulation short, 65 gives 650 ns at 100 MHz
`define SCCB_DIV4_END 4

// number of register writes in the init table
`define CAM_INIT_LEN 6

// apb byte offsets, one word each
`define REG_CTRL   4'h0
`define REG_ID     4'h4
`define REG_WDATA  4'h8
`define REG_STATUS 4'hc

`endif

//--- common/cam_cfg_pkg.sv
// types for the camera config subsystem
// sccb master states, sequencer opcodes, register write word, init table

`include "cam_cfg_params.svh"

package cam_cfg_pkg;

  // sccb master fsm
  typedef enum logic [2:0] {
    idle,       // waiting for a command, bus released
    init_seq,   // start condition
    send_byte,  // eight data bits, msb first
    dont_care,  // ninth bit, line released
    end_seq     // stop condition
  } sccb_state_e;

  // work requested by the apb block
  typedef enum logic [1:0] {
    op_none,
    op_single,  // one write from ID and WDATA
    op_table    // walk the init table
  } seq_op_e;

  // one sensor register write
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } cam_reg_write_t;

  // ov7670 style bring-up sequence
  localparam cam_reg_write_t cam_init_table [`CAM_INIT_LEN] = '{
    '{addr: 8'h12, data: 8'h80},  // COM7 soft reset
    '{addr: 8'h11, data: 8'h01},  // CLKRC prescale by 2
    '{addr: 8'h12, data: 8'h04},  // COM7 rgb output
    '{addr: 8'h40, data: 8'hd0},  // COM15 rgb565 full range
    '{addr: 8'h3a, data: 8'h04},  // TSLB output sequence
    '{addr: 8'h8c, data: 8'h00}   // RGB444 off
  };

endpackage

//--- common/sccb_cmd_if.sv
// sccb command channel between sequencer and master
// start/ready handshake, done pulse at the end of the stop sequence

`timescale 1ns/1ns

interface sccb_cmd_if;

  logic                        start;  // command valid
  logic [6:0]                  id;     // 7-bit slave id
  cam_cfg_pkg::cam_reg_write_t wr;     // register address and data
  logic                        ready;  // master idle, sampled with start
  logic                        done;   // one cycle at end of stop

  // sequencer side
  modport seq (
    output start, id, wr,
    input  ready, done
  );

  // master side
  modport master (
    input  start, id, wr,
    output ready, done
  );

endinterface

//--- sccb/sccb_master.sv
// sccb write-only master
// three phase write: id with write bit, register address, data
// each bit split into four quarter slots by a clock divider

`timescale 1ns/1ns
`include "cam_cfg_params.svh"

module sccb_master (
  input  logic       rst,       // system clock
  input  logic       clk,       // async reset, active high
  sccb_cmd_if.master cmd,
  output logic       sclk,      // sccb clock pin
  output logic       sdat_on,   // drive enable for sdat
  output logic       sdat_out   // sdat value when driven
);

  localparam int DIV4_END = `SCCB_DIV4_END;
  localparam int DIV_W    = (DIV4_END > 1) ? $clog2(DIV4_END) : 1;

  cam_cfg_pkg::sccb_state_e state, state_nx;

  logic [DIV_W-1:0] div_cnt;    // clocks within a quarter
  logic [1:0]       qtr_cnt;    // quarter within a bit
  logic [2:0]       bit_cnt;    // counts down 7 to 0
  logic [1:0]       phase_cnt;  // id, address, data
  logic [23:0]      shreg;      // outgoing bits, msb on the line

  logic active;
  logic qtr_end;
  logic bit_end;
  logic byte_end;
  logic accept;

  assign active   = (state != cam_cfg_pkg::idle);
  assign qtr_end  = (div_cnt == DIV_W'(DIV4_END - 1));
  assign bit_end  = qtr_end && (qtr_cnt == 2'd3);
  assign byte_end = bit_end && (bit_cnt == 3'd0);
  assign accept   = cmd.start && cmd.ready;

  // not ready while held in reset
  assign cmd.ready = (state == cam_cfg_pkg::idle) && !clk;
  assign cmd.done  = (state == cam_cfg_pkg::end_seq) && bit_end;

  // quarter-period divider, parked at zero while idle
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      div_cnt <= '0;
    end else if (!active || qtr_end) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // quarter counter wraps 3 -> 0 on its own
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      qtr_cnt <= 2'd0;
    end else if (!active) begin
      qtr_cnt <= 2'd0;
    end else if (qtr_end) begin
      qtr_cnt <= qtr_cnt + 2'd1;
    end
  end

  // bit counter only runs inside a byte
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      bit_cnt <= 3'd7;
    end else if (state != cam_cfg_pkg::send_byte) begin
      bit_cnt <= 3'd7;
    end else if (bit_end) begin
      bit_cnt <= bit_cnt - 3'd1;
    end
  end

  // one phase per byte, advanced after each don't-care bit
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      phase_cnt <= 2'd0;
    end else if (!active) begin
      phase_cnt <= 2'd0;
    end else if ((state == cam_cfg_pkg::dont_care) && bit_end) begin
      phase_cnt <= phase_cnt + 2'd1;
    end
  end

  // payload, write bit is 0
  always_ff @(posedge rst) begin
    if (accept) begin
      shreg <= {cmd.id, 1'b0, cmd.wr};
    end else if ((state == cam_cfg_pkg::send_byte) && bit_end) begin
      shreg <= {shreg[22:0], 1'b1};  // fill with idle level
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= cam_cfg_pkg::idle;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      cam_cfg_pkg::idle:      if (accept)   state_nx = cam_cfg_pkg::init_seq;
      cam_cfg_pkg::init_seq:  if (bit_end)  state_nx = cam_cfg_pkg::send_byte;
      cam_cfg_pkg::send_byte: if (byte_end) state_nx = cam_cfg_pkg::dont_care;
      cam_cfg_pkg::dont_care: begin
        if (bit_end) begin
          // third byte done -> stop, else next byte
          if (phase_cnt == 2'd2) begin
            state_nx = cam_cfg_pkg::end_seq;
          end else begin
            state_nx = cam_cfg_pkg::send_byte;
          end
        end
      end
      cam_cfg_pkg::end_seq:   if (bit_end)  state_nx = cam_cfg_pkg::idle;
      default:                state_nx = cam_cfg_pkg::idle;
    endcase
  end

  // pin decode from state and quarter
  // sclk high in quarters 1 and 2 of every data bit
  always_comb begin
    sclk     = 1'b1;
    sdat_on  = 1'b0;
    sdat_out = 1'b1;
    case (state)
      cam_cfg_pkg::init_seq: begin
        sdat_on  = 1'b1;
        sdat_out = (qtr_cnt == 2'd0);  // falls at q1 with sclk high = start
        sclk     = (qtr_cnt != 2'd3);
      end
      cam_cfg_pkg::send_byte: begin
        sdat_on  = 1'b1;
        sdat_out = shreg[23];
        sclk     = qtr_cnt[0] ^ qtr_cnt[1];
      end
      cam_cfg_pkg::dont_care: begin
        sclk     = qtr_cnt[0] ^ qtr_cnt[1];  // line released, slave may ack
      end
      cam_cfg_pkg::end_seq: begin
        sdat_on  = 1'b1;
        sclk     = (qtr_cnt != 2'd0);
        sdat_out = qtr_cnt[1];  // rises at q2 with sclk high = stop
      end
      default: begin
        sclk     = 1'b1;  // bus idle
      end
    endcase
  end

endmodule

//--- tests/sccb_bus_monitor.sv
// sccb bus monitor for the testbench
// samples sclk and the resolved sdat line once per system clock
// decodes start, three bytes with don't-care bits, stop, flags protocol errors

`timescale 1ns/1ns

module sccb_bus_monitor (
  input  logic       rst,          // system clock
  input  logic       clk,          // async reset, active high
  input  logic       sclk,
  input  logic       sdat_on,
  input  logic       sdat_out,
  output logic       frame_valid,  // one cycle per complete frame
  output logic [6:0] frame_id,
  output logic       frame_rw,
  output logic [7:0] frame_addr,
  output logic [7:0] frame_data,
  output logic       proto_err     // one cycle per detected error
);

  logic        sda;       // line with pull-up
  logic        scl_q;
  logic        sda_q;
  logic        in_frame;
  logic [4:0]  bit_idx;   // sclk rising edges since start
  logic [23:0] payload;   // data bits only, don't-care bits dropped

  assign sda = sdat_on ? sdat_out : 1'b1;

  // pins change after the rising edge, so sample on the falling edge
  always @(negedge rst or posedge clk) begin
    if (clk) begin
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      in_frame    <= 1'b0;
      bit_idx     <= 5'd0;
      payload     <= '0;
      frame_valid <= 1'b0;
      frame_id    <= '0;
      frame_rw    <= 1'b0;
      frame_addr  <= '0;
      frame_data  <= '0;
      proto_err   <= 1'b0;
    end else begin
      scl_q       <= sclk;
      sda_q       <= sda;
      frame_valid <= 1'b0;
      proto_err   <= 1'b0;
      if (scl_q && sclk && sda_q && !sda) begin  // sda falls, scl high
        if (in_frame) begin
          $display("bus monitor at %0t: sda fell while sclk high inside a frame", $time);
          proto_err <= 1'b1;
        end
        in_frame <= 1'b1;
        bit_idx  <= 5'd0;
      end else if (scl_q && sclk && !sda_q && sda) begin  // sda rises, scl high
        if (!in_frame || (bit_idx != 5'd28)) begin
          $display("bus monitor at %0t: sda rose while sclk high before frame end", $time);
          proto_err <= 1'b1;
        end else begin
          frame_valid <= 1'b1;
          frame_id    <= payload[23:17];
          frame_rw    <= payload[16];
          frame_addr  <= payload[15:8];
          frame_data  <= payload[7:0];
        end
        in_frame <= 1'b0;
      end else if (in_frame && !scl_q && sclk) begin
        if ((bit_idx == 5'd8) || (bit_idx == 5'd17) || (bit_idx == 5'd26)) begin
          if (sdat_on) begin
            $display("bus monitor at %0t: sdat driven in a don't-care bit", $time);
            proto_err <= 1'b1;
          end
        end else if (bit_idx < 5'd27) begin
          payload <= {payload[22:0], sda};  // msb first
        end else if ((bit_idx != 5'd27) || sda) begin
          // only one clock with sda low may precede the stop
          $display("bus monitor at %0t: unexpected sclk pulse before stop", $time);
          proto_err <= 1'b1;
        end
        bit_idx <= bit_idx + 5'd1;
      end
    end
  end

endmodule

//--- tests/tb_cam_cfg.sv
// testbench for the camera config subsystem
// random single writes and table walks launched over apb
// frames decoded from the sccb pins and checked against an expected-write queue

`timescale 1ns/1ns
`include "cam_cfg_params.svh"

module tb_cam_cfg;

  localparam int NUM_OPS     = 12;
  localparam int FRAME_CLKS  = 116 * `SCCB_DIV4_END;  // one sensor write on the bus
  localparam int WATCHDOG_NS = NUM_OPS * `CAM_INIT_LEN * FRAME_CLKS * 4 + 20000;

  logic        rst;  // clock
  logic        clk;  // reset
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;
  logic        sclk;
  logic        sdat_on;
  logic        sdat_out;
  logic        frame_valid;
  logic [6:0]  frame_id;
  logic        frame_rw;
  logic [7:0]  frame_addr;
  logic [7:0]  frame_data;
  logic        proto_err;

  logic [31:0] lfsr_state;
  logic [22:0] exp_q [$];  // {id, addr, data} per expected frame
  logic [22:0] frame_exp;
  logic [7:0]  exp_count;  // model of the STATUS write counter
  int          cycle = 0;

  cam_cfg_top cam_cfg_top_inst (
    .rst(rst), .clk(clk), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
    .sclk(sclk), .sdat_on(sdat_on), .sdat_out(sdat_out)
  );

  sccb_bus_monitor sccb_bus_monitor_inst (
    .rst(rst), .clk(clk), .sclk(sclk), .sdat_on(sdat_on), .sdat_out(sdat_out),
    .frame_valid(frame_valid), .frame_id(frame_id), .frame_rw(frame_rw),
    .frame_addr(frame_addr), .frame_data(frame_data), .proto_err(proto_err)
  );

  initial begin
    rst = 1'b0;
    forever #2 rst = ~rst;  // 4 ns period
  end

  always @(posedge rst) cycle <= cycle + 1;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
  endtask

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // setup then access phase with outputs sampled mid access phase
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge rst);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge rst);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    @(negedge rst);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value($sformatf("pslverr on write to 0x%0h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, 32'd0, rdata, err);
    check_value($sformatf("pslverr on read of 0x%0h", addr), 32'(err), 32'd0);
  endtask

  // one launch with its error probes, status polling and status checks
  task automatic run_op();
    logic [31:0] rdata;
    logic [6:0]  id;
    logic [15:0] word;
    logic [1:0]  ctrl;
    logic [3:0]  bad_addr;
    logic        err;
    logic        seen_busy;
    int          t_launch;
    id   = 7'(rand_bits(7));
    word = 16'(rand_bits(16));
    ctrl = 2'(rand_bits(2));
    if (ctrl == 2'b00) ctrl = 2'b01;
    apb_write(`REG_ID, {25'd0, id}, 1'b0);
    apb_write(`REG_WDATA, {16'd0, word}, 1'b0);
    apb_read(`REG_ID, rdata);
    check_value("ID", rdata, {25'd0, id});
    if (ctrl[1]) begin  // table walk wins over single
      for (int i = 0; i < `CAM_INIT_LEN; i++) begin
        exp_q.push_back({id, cam_cfg_pkg::cam_init_table[i]});
      end
      exp_count = exp_count + 8'(`CAM_INIT_LEN);
    end else begin
      exp_q.push_back({id, word});
      exp_count = exp_count + 8'd1;
    end
    t_launch = cycle;
    apb_write(`REG_CTRL, {30'd0, ctrl}, 1'b0);
    bad_addr = 4'(rand_bits(4));
    if (bad_addr[1:0] == 2'b00) bad_addr[0] = 1'b1;  // off the word grid
    apb_access(1'(rand_bits(1)), bad_addr, rand_bits(32), rdata, err);
    check_value("pslverr on unmapped offset", 32'(err), 32'd1);
    apb_write(`REG_CTRL, 32'(rand_bits(2)) | 32'd1, 1'b1);  // launch while busy
    seen_busy = 1'b0;
    do begin
      apb_read(`REG_STATUS, rdata);
      if (rdata[0]) seen_busy = 1'b1;
    end while (!rdata[1]);
    assert (seen_busy) else fail_now("STATUS busy was never seen during the operation");
    if (!ctrl[1]) begin
      assert (cycle - t_launch >= FRAME_CLKS)
        else fail_now("STATUS done was readable before a full frame time had passed");
    end
    check_value("STATUS busy", 32'(rdata[0]), 32'd0);
    check_value("STATUS count", 32'(rdata[15:8]), 32'(exp_count));
    apb_read(`REG_STATUS, rdata);
    check_value("STATUS after done read", rdata, {16'd0, exp_count, 8'd0});
    check_value("frames pending", 32'(exp_q.size()), 32'd0);
    repeat (rand_bits(4)) @(negedge rst);  // idle gap
  endtask

  // frames from the monitor against the expected queue
  always @(posedge rst) begin
    if (!clk && frame_valid) begin
      assert (exp_q.size() != 0) else fail_now("frame on the bus with no write pending");
      frame_exp = exp_q.pop_front();
      check_value("frame id", 32'(frame_id), 32'(frame_exp[22:16]));
      check_value("frame write bit", 32'(frame_rw), 32'd0);
      check_value("frame address", 32'(frame_addr), 32'(frame_exp[15:8]));
      check_value("frame data", 32'(frame_data), 32'(frame_exp[7:0]));
    end
    assert (clk || !proto_err) else fail_now("bus monitor reported a protocol error");
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now($sformatf("timeout: run still going after %0d ns", WATCHDOG_NS));
  end

  initial begin
    logic [31:0] rdata;
    lfsr_state = 32'hb607;
    exp_count  = 8'd0;
    clk        = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 4'd0;
    pwdata     = 32'd0;
    repeat (8) @(negedge rst);
    clk = 1'b0;
    @(negedge rst);
    check_value("sclk", 32'(sclk), 32'd1);  // bus idle after reset
    check_value("sdat_on", 32'(sdat_on), 32'd0);
    apb_read(`REG_STATUS, rdata);
    check_value("STATUS after reset", rdata, 32'd0);
    for (int n = 0; n < NUM_OPS; n++) run_op();
    repeat (10) @(negedge rst);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog/cam_cfg_apb_regs.sv
// apb slave register block, zero wait states
// CTRL launches work, ID and WDATA hold the single write
// STATUS gives busy, sticky done flag and a write counter

`timescale 1ns/1ns
`include "cam_cfg_params.svh"

module cam_cfg_apb_regs (
  input  logic                        rst,        // clock
  input  logic                        clk,        // async reset, active high
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [3:0]                  paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pslverr,
  output cam_cfg_pkg::seq_op_e        op,         // work type, valid with go
  output logic                        go,         // one cycle launch
  output logic [6:0]                  slave_id,
  output cam_cfg_pkg::cam_reg_write_t single_wr,
  input  logic                        busy,
  input  logic                        wr_done     // one per finished sensor write
);

  logic       access;
  logic       wr_acc;
  logic       rd_acc;
  logic       mapped;
  logic       busy_all;     // includes the launch cycle
  logic       ctrl_wr;
  logic       busy_q;
  logic       done_flag;
  logic [7:0] wr_count;

  assign access   = psel && penable;
  assign wr_acc   = access && pwrite;
  assign rd_acc   = access && !pwrite;
  assign busy_all = busy || go;
  assign ctrl_wr  = wr_acc && (paddr == `REG_CTRL);

  always_comb begin
    case (paddr)
      `REG_CTRL, `REG_ID, `REG_WDATA, `REG_STATUS: mapped = 1'b1;
      default:                                     mapped = 1'b0;
    endcase
  end

  // unmapped offset or launch attempt while busy
  assign pslverr = access && (!mapped || (pwrite && (paddr == `REG_CTRL) && busy_all));

  // launch, table walk wins when both bits set
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      go <= 1'b0;
      op <= cam_cfg_pkg::op_none;
    end else if (ctrl_wr && !busy_all && (pwdata[1:0] != 2'b00)) begin
      go <= 1'b1;
      op <= pwdata[1] ? cam_cfg_pkg::op_table : cam_cfg_pkg::op_single;
    end else begin
      go <= 1'b0;
    end
  end

  // id and single write word
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      slave_id  <= 7'h21;  // ov7670 write address 0x42 >> 1
      single_wr <= '0;
    end else if (wr_acc) begin
      if (paddr == `REG_ID)    slave_id  <= pwdata[6:0];
      if (paddr == `REG_WDATA) single_wr <= pwdata[15:0];
    end
  end

  // status flags
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      busy_q    <= 1'b0;
      done_flag <= 1'b0;
      wr_count  <= 8'd0;
    end else begin
      busy_q <= busy;
      if (busy_q && !busy) begin
        done_flag <= 1'b1;  // set beats a same-cycle read clear
      end else if (rd_acc && (paddr == `REG_STATUS)) begin
        done_flag <= 1'b0;
      end
      if (wr_done) wr_count <= wr_count + 8'd1;  // wraps at 256
    end
  end

  // read mux, CTRL reads as zero
  always_comb begin
    case (paddr)
      `REG_ID:     prdata = {25'd0, slave_id};
      `REG_WDATA:  prdata = {16'd0, single_wr};
      `REG_STATUS: prdata = {16'd0, wr_count, 6'd0, done_flag, busy_all};
      default:     prdata = 32'd0;
    endcase
  end

endmodule

//--- verilog/cam_cfg_sequencer.sv
// turns a single write or the init table into sccb commands
// one command in flight, next one issued after done

`timescale 1ns/1ns
`include "cam_cfg_params.svh"

module cam_cfg_sequencer (
  input  logic                        rst,        // clock
  input  logic                        clk,        // async reset, active high
  input  cam_cfg_pkg::seq_op_e        op,
  input  logic                        go,
  input  logic [6:0]                  slave_id,
  input  cam_cfg_pkg::cam_reg_write_t single_wr,
  output logic                        busy,
  output logic                        wr_done,
  sccb_cmd_if.seq                     cmd
);

  localparam int IDX_W = (`CAM_INIT_LEN > 1) ? $clog2(`CAM_INIT_LEN) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`CAM_INIT_LEN - 1);

  typedef enum logic [1:0] {
    idle,
    issue,      // start high until the master takes it
    wait_done
  } seq_state_e;

  seq_state_e                  state;
  cam_cfg_pkg::seq_op_e        op_q;
  logic [IDX_W-1:0]            idx;       // table entry in flight
  logic [6:0]                  id_q;
  cam_cfg_pkg::cam_reg_write_t single_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= idle;
      op_q  <= cam_cfg_pkg::op_none;
      idx   <= '0;
    end else begin
      case (state)
        idle: begin
          if (go && (op != cam_cfg_pkg::op_none)) begin
            op_q  <= op;
            idx   <= '0;
            state <= issue;
          end
        end
        issue: if (cmd.ready) state <= wait_done;
        wait_done: begin
          if (cmd.done) begin
            // done cycle is the single idle clock between writes
            if ((op_q == cam_cfg_pkg::op_table) && (idx != LAST_IDX)) begin
              idx   <= idx + 1'b1;
              state <= issue;
            end else begin
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // latch id and word at launch so later APB writes do not disturb a walk
  always_ff @(posedge rst) begin
    if ((state == idle) && go) begin
      id_q     <= slave_id;
      single_q <= single_wr;
    end
  end

  assign cmd.start = (state == issue);
  assign cmd.id    = id_q;
  assign cmd.wr    = (op_q == cam_cfg_pkg::op_table) ? cam_cfg_pkg::cam_init_table[idx]
                                                     : single_q;

  assign busy    = (state != idle);
  assign wr_done = (state == wait_done) && cmd.done;

endmodule

//--- verilog/cam_cfg_top.sv
// camera config top level
// apb register block, command sequencer and sccb master

`timescale 1ns/1ns

module cam_cfg_top (
  input  logic        rst,       // clock
  input  logic        clk,       // async reset, active high
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  output logic        sclk,
  output logic        sdat_on,   // low = line released, pulled high
  output logic        sdat_out
);

  cam_cfg_pkg::seq_op_e        op;
  logic                        go;
  logic [6:0]                  slave_id;
  cam_cfg_pkg::cam_reg_write_t single_wr;
  logic                        busy;
  logic                        wr_done;

  sccb_cmd_if cmd_if ();  // sequencer -> master

  cam_cfg_apb_regs cam_cfg_apb_regs_inst (
    .rst       (rst),
    .clk       (clk),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .op        (op),
    .go        (go),
    .slave_id  (slave_id),
    .single_wr (single_wr),
    .busy      (busy),
    .wr_done   (wr_done)
  );

  cam_cfg_sequencer cam_cfg_sequencer_inst (
    .rst       (rst),
    .clk       (clk),
    .op        (op),
    .go        (go),
    .slave_id  (slave_id),
    .single_wr (single_wr),
    .busy      (busy),
    .wr_done   (wr_done),
    .cmd       (cmd_if.seq)
  );

  sccb_master sccb_master_inst (
    .rst      (rst),
    .clk      (clk),
    .cmd      (cmd_if.master),
    .sclk     (sclk),
    .sdat_on  (sdat_on),
    .sdat_out (sdat_out)
  );

endmodule
